//--- hw/sensor_pkg.sv
`default_nettype none

package sensor_pkg;

	// apb data word, also one sensor register slice
	typedef logic [31:0] word_t;

	// word offset from vpaddr[7:2]
	typedef logic [5:0] reg_off_t;

	// one channel's raw sensor vector
	typedef logic [63:0] sensor_vec_t;

	localparam int chan_count     = 2;
	localparam int words_per_chan = 2;
	localparam int slice_count    = chan_count * words_per_chan; // slice = chan*2 + word

	localparam int chan_enc = 0; // encrypt core sensors
	localparam int chan_dec = 1; // decrypt core sensors

	// register map, channel base at 0x30 + 8*chan
	localparam reg_off_t off_control_base = 6'h30;
	localparam int       off_chan_stride  = 8;
	localparam reg_off_t off_select_base  = 6'd2; // relative to channel base
	localparam reg_off_t off_alarm_base   = 6'd4;
	localparam reg_off_t off_enable       = 6'd6;
	localparam reg_off_t off_all_ones     = 6'h3f;

	localparam word_t all_ones_word = 32'hFFFF_FFFF;
	localparam word_t unmapped_word = 32'hAAAA_AAAA;
	localparam word_t clear_code    = 32'h0000_0001; // control value that wipes the alarm word
	localparam word_t select_reset  = 32'hFFFF_FFFF; // every sensor bit unmasked

	// absolute word offset of a register inside a channel block
	function automatic reg_off_t chan_off(input int ch, input reg_off_t rel);
		return reg_off_t'(int'(off_control_base) + ch * off_chan_stride + int'(rel));
	endfunction

endpackage

`default_nettype wire

//--- hw/apb_write_decode.sv
`default_nettype none

module apb_write_decode #(
	parameter int apb_index = 8,
	parameter int nslv      = 16
)
(
	input  logic [0:nslv-1]                    vpsel,
	input  logic                               vpenable,
	input  logic                               vpwrite,
	input  logic [31:0]                        vpaddr,
	output logic [sensor_pkg::slice_count-1:0] ctrl_we,
	output logic [sensor_pkg::slice_count-1:0] sel_we,
	output logic [sensor_pkg::chan_count-1:0]  en_we
);
	import sensor_pkg::*;

	logic     wr_stb;
	reg_off_t off;

	// plain apb strobe, no wait states
	assign wr_stb = vpsel[apb_index] & vpenable & vpwrite;
	assign off    = vpaddr[7:2];

	// at most one enable per access
	// alarm words have no write enable, they stay read-only
	always_comb
	begin
		ctrl_we = '0;
		sel_we  = '0;
		en_we   = '0;
		if (wr_stb)
		begin
			for (int ch = 0; ch < chan_count; ch++)
			begin
				for (int w = 0; w < words_per_chan; w++)
				begin
					if (off == chan_off(ch, reg_off_t'(w)))
					begin
						ctrl_we[ch*words_per_chan + w] = 1'b1; // control word
					end
					if (off == chan_off(ch, off_select_base + reg_off_t'(w)))
					begin
						sel_we[ch*words_per_chan + w] = 1'b1; // select word
					end
				end
				if (off == chan_off(ch, off_enable))
				begin
					en_we[ch] = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/alarm_word_slice.sv
`default_nettype none

module alarm_word_slice
(
	input  logic               vclk,
	input  logic               vrst,
	input  logic               ctrl_we,
	input  logic               sel_we,
	input  sensor_pkg::word_t  vpwdata,
	input  sensor_pkg::word_t  sensor,
	output sensor_pkg::word_t  ctrl_q,
	output sensor_pkg::word_t  sel_q,
	output sensor_pkg::word_t  alarm_q
);
	import sensor_pkg::*;

	logic clearing;

	// clear follows the registered control word
	assign clearing = (ctrl_q == clear_code);

	// software registers
	always_ff @(posedge vclk)
	begin
		if (!vrst)
		begin
			ctrl_q <= '0;
			sel_q  <= select_reset; // all sensors visible after reset
		end
		else
		begin
			if (ctrl_we)
			begin
				ctrl_q <= vpwdata;
			end
			if (sel_we)
			begin
				sel_q <= vpwdata;
			end
		end
	end

	// sticky alarm capture
	always_ff @(posedge vclk)
	begin
		if (!vrst)
		begin
			alarm_q <= '0;
		end
		else if (clearing)
		begin
			alarm_q <= '0; // sensors ignored while held in clear
		end
		else
		begin
			alarm_q <= alarm_q | sensor;
		end
	end

endmodule

`default_nettype wire

//--- hw/alarm_readback.sv
`default_nettype none

module alarm_readback
(
	input  logic                                                    vclk,
	input  logic                                                    vrst,
	input  logic [sensor_pkg::chan_count-1:0]                       en_we,
	input  sensor_pkg::word_t                                       vpwdata,
	input  logic [31:0]                                             vpaddr,
	input  sensor_pkg::word_t [sensor_pkg::slice_count-1:0]         ctrl_bus,
	input  sensor_pkg::word_t [sensor_pkg::slice_count-1:0]         sel_bus,
	input  sensor_pkg::word_t [sensor_pkg::slice_count-1:0]         alarm_bus,
	output sensor_pkg::word_t                                       vprdata,
	output logic                                                    alarm_enc,
	output logic                                                    alarm_dec
);
	import sensor_pkg::*;

	word_t [chan_count-1:0] en_q;     // per-channel enable words
	logic  [chan_count-1:0] chan_hit; // any selected alarm bit in the channel
	reg_off_t               off;

	assign off = vpaddr[7:2];

	// enable registers, only bit 0 gates the output
	always_ff @(posedge vclk)
	begin
		if (!vrst)
		begin
			en_q <= '0;
		end
		else
		begin
			for (int ch = 0; ch < chan_count; ch++)
			begin
				if (en_we[ch])
				begin
					en_q[ch] <= vpwdata;
				end
			end
		end
	end

	// per-bit mask, then or over both words of the channel
	always_comb
	begin
		chan_hit = '0;
		for (int ch = 0; ch < chan_count; ch++)
		begin
			for (int w = 0; w < words_per_chan; w++)
			begin
				chan_hit[ch] = chan_hit[ch]
					| (|(alarm_bus[ch*words_per_chan + w] & sel_bus[ch*words_per_chan + w]));
			end
		end
	end

	assign alarm_enc = en_q[chan_enc][0] & chan_hit[chan_enc];
	assign alarm_dec = en_q[chan_dec][0] & chan_hit[chan_dec];

	// zero-latency read mux
	always_comb
	begin
		vprdata = unmapped_word; // fallback for holes in the map
		if (off == off_all_ones)
		begin
			vprdata = all_ones_word;
		end
		for (int ch = 0; ch < chan_count; ch++)
		begin
			for (int w = 0; w < words_per_chan; w++)
			begin
				if (off == chan_off(ch, reg_off_t'(w)))
				begin
					vprdata = ctrl_bus[ch*words_per_chan + w];
				end
				if (off == chan_off(ch, off_select_base + reg_off_t'(w)))
				begin
					vprdata = sel_bus[ch*words_per_chan + w];
				end
				if (off == chan_off(ch, off_alarm_base + reg_off_t'(w)))
				begin
					vprdata = alarm_bus[ch*words_per_chan + w];
				end
			end
			if (off == chan_off(ch, off_enable))
			begin
				vprdata = en_q[ch]; // full word reads back, not just bit 0
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/sensor_monitor_top.sv
`default_nettype none

module sensor_monitor_top #(
	parameter int apb_index = 8,
	parameter int nslv      = 16
)
(
	input  logic                    vclk,
	input  logic                    vrst,

	// apb slave side
	input  logic [0:nslv-1]         vpsel,
	input  logic                    vpenable,
	input  logic [31:0]             vpaddr,
	input  logic                    vpwrite,
	input  sensor_pkg::word_t       vpwdata,
	output sensor_pkg::word_t       vprdata,

	// sensor vectors from the cipher cores
	input  sensor_pkg::sensor_vec_t sensor_enc,
	input  sensor_pkg::sensor_vec_t sensor_dec,
	output logic                    alarm_enc,
	output logic                    alarm_dec
);
	import sensor_pkg::*;

	logic  [slice_count-1:0] ctrl_we;
	logic  [slice_count-1:0] sel_we;
	logic  [chan_count-1:0]  en_we;

	word_t [slice_count-1:0] sensor_bus; // slice-indexed sensor words
	word_t [slice_count-1:0] ctrl_bus;
	word_t [slice_count-1:0] sel_bus;
	word_t [slice_count-1:0] alarm_bus;

	// enc low word lands in slice 0, dec high word in slice 3
	assign sensor_bus = {sensor_dec, sensor_enc};

	apb_write_decode #(
		.apb_index (apb_index),
		.nslv      (nslv)
	) u_decode (
		.vpsel    (vpsel),
		.vpenable (vpenable),
		.vpwrite  (vpwrite),
		.vpaddr   (vpaddr),
		.ctrl_we  (ctrl_we),
		.sel_we   (sel_we),
		.en_we    (en_we)
	);

	for (genvar s = 0; s < slice_count; s++)
	begin : g_slice
		alarm_word_slice u_slice (
			.vclk    (vclk),
			.vrst    (vrst),
			.ctrl_we (ctrl_we[s]),
			.sel_we  (sel_we[s]),
			.vpwdata (vpwdata),
			.sensor  (sensor_bus[s]),
			.ctrl_q  (ctrl_bus[s]),
			.sel_q   (sel_bus[s]),
			.alarm_q (alarm_bus[s])
		);
	end

	alarm_readback u_readback (
		.vclk      (vclk),
		.vrst      (vrst),
		.en_we     (en_we),
		.vpwdata   (vpwdata),
		.vpaddr    (vpaddr),
		.ctrl_bus  (ctrl_bus),
		.sel_bus   (sel_bus),
		.alarm_bus (alarm_bus),
		.vprdata   (vprdata),
		.alarm_enc (alarm_enc),
		.alarm_dec (alarm_dec)
	);

endmodule

`default_nettype wire

//--- testbench/sensor_monitor_asserts.sv
`default_nettype none

module sensor_monitor_asserts
(
	input  logic              vclk,
	input  logic              vrst,
	input  logic [31:0]       vpaddr,
	input  sensor_pkg::word_t vprdata,
	input  logic              alarm_enc,
	input  logic              alarm_dec,
	input  logic              en_enc,
	input  logic              en_dec
);
	import sensor_pkg::*;

	logic [5:0] off;

	assign off = vpaddr[7:2];

	// enable bit 0 gates each channel
	enc_gated: assert property (@(posedge vclk) disable iff (!vrst) !en_enc |-> !alarm_enc)
	else $error("alarm_enc high with its enable bit clear");

	dec_gated: assert property (@(posedge vclk) disable iff (!vrst) !en_dec |-> !alarm_dec)
	else $error("alarm_dec high with its enable bit clear");

	// holes below the channel blocks and at 0x37
	unmapped_read: assert property (@(posedge vclk)
		(off < 6'h30 || off == 6'h37) |-> vprdata == unmapped_word)
	else $error("unmapped offset did not read back the fill word");

	quiet_after_reset: assert property (@(posedge vclk) !vrst |=> !alarm_enc && !alarm_dec)
	else $error("alarm output high right after reset");

endmodule

bind sensor_monitor_top sensor_monitor_asserts sensor_monitor_asserts_inst (
	.vclk      (vclk),
	.vrst      (vrst),
	.vpaddr    (vpaddr),
	.vprdata   (vprdata),
	.alarm_enc (alarm_enc),
	.alarm_dec (alarm_dec),
	.en_enc    (u_readback.en_q[0][0]),
	.en_dec    (u_readback.en_q[1][0])
);

`default_nettype wire

//--- testbench/sensor_monitor_tb.sv
`default_nettype none

module sensor_monitor_tb;
	import sensor_pkg::*;

	localparam int apb_slot   = 8;
	localparam int slot_count = 16;

	logic                  vclk;
	logic                  vrst;
	logic [0:slot_count-1] vpsel;
	logic                  vpenable;
	logic [31:0]           vpaddr;
	logic                  vpwrite;
	word_t                 vpwdata;
	word_t                 vprdata;
	sensor_vec_t           sensor_enc;
	sensor_vec_t           sensor_dec;
	logic                  alarm_enc;
	logic                  alarm_dec;

	// reference model, slice = chan*2 + word
	word_t       ctrl_m [4];
	word_t       sel_m [4];
	word_t       alarm_m [4];
	word_t       en_m [2];

	// control, select and enable words that software can write
	logic [5:0] rw_offs [10] = '{6'h30, 6'h31, 6'h38, 6'h39, 6'h32, 6'h33, 6'h3a, 6'h3b,
		6'h36, 6'h3e};

	sensor_monitor_top #(
		.apb_index (apb_slot),
		.nslv      (slot_count)
	) sensor_monitor_top_inst (
		.vclk       (vclk),
		.vrst       (vrst),
		.vpsel      (vpsel),
		.vpenable   (vpenable),
		.vpaddr     (vpaddr),
		.vpwrite    (vpwrite),
		.vpwdata    (vpwdata),
		.vprdata    (vprdata),
		.sensor_enc (sensor_enc),
		.sensor_dec (sensor_dec),
		.alarm_enc  (alarm_enc),
		.alarm_dec  (alarm_dec)
	);

	initial
	begin
		vclk = 1'b0;
		forever #2 vclk = ~vclk;
	end

	// about 260 cycles of tests, so 1000 cycles is plenty
	initial
	begin
		#4000;
		$display("watchdog expired before the tests finished");
		$display("Test failures found");
		$fatal(1, "watchdog timeout");
	end

	// word s of the sensor inputs, low half is word 0
	function automatic word_t sensor_word(input int s);
		sensor_vec_t v;
		v = (s < 2) ? sensor_enc : sensor_dec;
		return (s % 2 == 0) ? v[31:0] : v[63:32];
	endfunction

	function automatic word_t model_read(input logic [5:0] off);
		int ch;
		int rel;
		if (off == 6'h3f)
			return 32'hFFFF_FFFF;
		if (off < 6'h30)
			return 32'hAAAA_AAAA;
		ch  = (int'(off) - 48) / 8;
		rel = (int'(off) - 48) % 8;
		if (rel < 2)
			return ctrl_m[ch*2 + rel];
		if (rel < 4)
			return sel_m[ch*2 + rel - 2];
		if (rel < 6)
			return alarm_m[ch*2 + rel - 4];
		if (rel == 6)
			return en_m[ch];
		return 32'hAAAA_AAAA; // hole at channel base + 7
	endfunction

	function automatic logic model_alarm(input int ch);
		word_t hit;
		hit = (alarm_m[2*ch] & sel_m[2*ch]) | (alarm_m[2*ch + 1] & sel_m[2*ch + 1]);
		return en_m[ch][0] & (|hit);
	endfunction

	function automatic logic [5:0] slice_off(input int s, input int rel);
		return 6'(48 + (s / 2) * 8 + (s % 2) + rel);
	endfunction

	function automatic word_t sparse_word();
		return $urandom() & $urandom() & $urandom(); // about one bit in eight
	endfunction

	// register behaviour at a rising edge
	task automatic model_update();
		int ch;
		int rel;
		if (!vrst)
		begin
			for (int s = 0; s < 4; s++)
			begin
				ctrl_m[s]  = '0;
				sel_m[s]   = 32'hFFFF_FFFF;
				alarm_m[s] = '0;
			end
			en_m[0] = '0;
			en_m[1] = '0;
		end
		else
		begin
			// old control value decides the clear
			for (int s = 0; s < 4; s++)
				alarm_m[s] = (ctrl_m[s] == 32'h1) ? '0 : (alarm_m[s] | sensor_word(s));
			if (vpsel[apb_slot] && vpenable && vpwrite && vpaddr[7:2] >= 6'h30)
			begin
				ch  = (int'(vpaddr[7:2]) - 48) / 8;
				rel = (int'(vpaddr[7:2]) - 48) % 8;
				if (rel < 2)
					ctrl_m[ch*2 + rel] = vpwdata;
				else if (rel < 4)
					sel_m[ch*2 + rel - 2] = vpwdata;
				else if (rel == 6)
					en_m[ch] = vpwdata;
			end
		end
	endtask

	task automatic report_mismatch(input string name, input word_t exp, input word_t act);
		$display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
		$display("Test failures found");
		$fatal(1, "output mismatch");
	endtask

	task automatic check_outputs();
		word_t exp_rd;
		exp_rd = model_read(vpaddr[7:2]);
		assert (vprdata === exp_rd)
		else report_mismatch("vprdata", exp_rd, vprdata);
		assert (alarm_enc === model_alarm(0))
		else report_mismatch("alarm_enc", word_t'(model_alarm(0)), word_t'(alarm_enc));
		assert (alarm_dec === model_alarm(1))
		else report_mismatch("alarm_dec", word_t'(model_alarm(1)), word_t'(alarm_dec));
	endtask

	// one clock, outputs checked at the falling edge where they are stable
	task automatic cycle();
		@(posedge vclk);
		model_update();
		@(negedge vclk);
		check_outputs();
	endtask

	task automatic apb_drive(input int slot, input logic en, input logic wr,
		input logic [5:0] off, input word_t data);
		vpsel       = '0;
		vpsel[slot] = 1'b1;
		vpenable    = en;
		vpwrite     = wr;
		vpaddr      = {24'h0, off, 2'b00};
		vpwdata     = data;
		cycle();
	endtask

	task automatic write_reg(input logic [5:0] off, input word_t data);
		apb_drive(apb_slot, 1'b1, 1'b1, off, data);
	endtask

	task automatic read_reg(input logic [5:0] off);
		apb_drive(apb_slot, 1'b0, 1'b0, off, '0);
	endtask

	// sensors high for one cycle only
	task automatic pulse_and_read(input logic [5:0] off);
		sensor_enc = {sparse_word(), sparse_word()};
		sensor_dec = {sparse_word(), sparse_word()};
		read_reg(off);
		sensor_enc = '0;
		sensor_dec = '0;
	endtask

	initial
	begin
		int pick;
		int rs;
		void'($urandom(36));
		vrst       = 1'b0;
		vpsel      = '0;
		vpenable   = 1'b0;
		vpaddr     = '0;
		vpwrite    = 1'b0;
		vpwdata    = '0;
		sensor_enc = '0;
		sensor_dec = '0;
		repeat (4) cycle();
		vrst = 1'b1;

		// reset values and the fixed map
		for (int o = 0; o < 64; o++)
			read_reg(6'(o));

		// readback of every writable word
		for (int i = 0; i < 10; i++)
		begin
			write_reg(rw_offs[i], $urandom());
			read_reg(rw_offs[i]);
		end
		for (int s = 0; s < 4; s++)
			write_reg(slice_off(s, 4), $urandom()); // alarm words are read-only
		apb_drive(apb_slot, 1'b0, 1'b1, 6'h30, $urandom()); // no vpenable
		apb_drive(3, 1'b1, 1'b1, 6'h32, $urandom());
		apb_drive(apb_slot + 1, 1'b1, 1'b1, 6'h36, $urandom());
		write_reg(6'h3f, $urandom());
		write_reg(6'h37, $urandom());
		write_reg(6'h10, $urandom());

		// sticky capture with all control words at zero
		for (int s = 0; s < 4; s++)
			write_reg(slice_off(s, 0), '0);
		for (int i = 0; i < 24; i++)
			pulse_and_read(slice_off(i % 4, 4));
		for (int s = 0; s < 4; s++)
			read_reg(slice_off(s, 4));

		// wipe all alarms, then mask and toggle enables
		for (int s = 0; s < 4; s++)
			write_reg(slice_off(s, 0), 32'h1);
		for (int s = 0; s < 4; s++)
			write_reg(slice_off(s, 0), '0);
		write_reg(6'h36, 32'h1);
		write_reg(6'h3e, 32'h1);
		for (int i = 0; i < 60; i++)
		begin
			pick = int'($urandom() % 4);
			rs   = int'($urandom() % 4);
			case (pick)
				0: write_reg(slice_off(rs, 2), ($urandom() % 3 == 0) ? '0 : sparse_word());
				1: write_reg((rs < 2) ? 6'h36 : 6'h3e, $urandom());
				2: pulse_and_read(slice_off(rs, 4));
				default: read_reg(6'($urandom()));
			endcase
		end

		// clear one slice at a time
		for (int s = 0; s < 4; s++)
		begin
			pulse_and_read(slice_off(s, 4));
			write_reg(slice_off(s, 0), 32'h1);
			for (int t = 0; t < 4; t++)
				read_reg(slice_off(t, 4)); // other slices keep their bits
			repeat (3) pulse_and_read(slice_off(s, 4));
			write_reg(slice_off(s, 0), '0);
			pulse_and_read(slice_off(s, 4));
			write_reg(slice_off(s, 0), 32'h2); // not the clear code
			pulse_and_read(slice_off(s, 4));
			read_reg(slice_off(s, 4));
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
hw/sensor_pkg.sv
hw/apb_write_decode.sv
hw/alarm_word_slice.sv
hw/alarm_readback.sv
hw/sensor_monitor_top.sv
testbench/sensor_monitor_asserts.sv
testbench/sensor_monitor_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator and run it
# any $fatal or failed assertion gives a nonzero exit status
verilator --binary --timing --assert --top-module sensor_monitor_tb \
	-f vlog.f -o sensor_monitor_sim \
	&& ./obj_dir/sensor_monitor_sim \
	|| exit 1
